//--- Bender.yml
package:
  name: fp_mac

sources:
  - logic/fp_mac_pkg.sv
  - logic/fp_special.sv
  - logic/fp_mul.sv
  - logic/fp_add.sv
  - logic/fp_mac_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/fp_mac_chk.sv
      - dv/fp_mac_tb.sv

//--- dv/fp_mac_chk.sv
`default_nettype none

module fp_mac_chk (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    out_low_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    // one out per strobe two cycles later
    two_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n, 2) |-> (out_valid == $past(in_valid, 2)))
        else $error("out_valid does not follow in_valid by two cycles");

endmodule

bind fp_mac_top fp_mac_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

`default_nettype wire

//--- dv/fp_mac_model.svh
`ifndef FP_MAC_MODEL_SVH
`define FP_MAC_MODEL_SVH

// galois lfsr stepped once per bit taken
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// expected a * b + c with truncation and no subnormals
function automatic logic [31:0] mac_expect(input logic [31:0] a, input logic [31:0] b,
                                           input logic [31:0] c);
    int     ea, eb, ec, pe, be, se, e;
    longint p, ms, mc, bm, sm, mag;
    logic   ps, sc, bs, an, bn, cn, ai, bi, ci, az, bz;
    ea = a[30:23];
    eb = b[30:23];
    ec = c[30:23];
    ps = a[31] ^ b[31];
    sc = c[31];
    an = (ea == 255) && (a[22:0] != 0);
    bn = (eb == 255) && (b[22:0] != 0);
    cn = (ec == 255) && (c[22:0] != 0);
    ai = (ea == 255) && !an;
    bi = (eb == 255) && !bn;
    ci = (ec == 255) && !cn;
    az = (ea == 0);
    bz = (eb == 0);
    if (an || bn || cn || (ai && bz) || (bi && az)) return 32'h7fff_ffff;
    if ((ai || bi) && ci && (ps != sc)) return 32'h7fff_ffff; // inf - inf
    if (ai || bi) return {ps, 8'hff, 23'h0};
    if (ci) return c;
    if (az || bz) return (ec == 0) ? 32'h0 : c; // zero product passes acc
    p = ((64'd1 << 23) | a[22:0]) * ((64'd1 << 23) | b[22:0]);
    pe = ea + eb - 127;
    if (p >= (64'd1 << 47)) begin
        ms = p >> 24;
        pe = pe + 1;
    end else begin
        ms = p >> 23;
    end
    if (pe < 1) return (ec == 0) ? 32'h0 : c;
    if (pe >= 255) return {ps, 8'hff, 23'h0};
    mc = (ec == 0) ? 0 : ((64'd1 << 23) | c[22:0]);
    if ((pe > ec) || ((pe == ec) && (ms >= mc))) begin
        bs = ps;
        be = pe;
        bm = ms;
        se = ec;
        sm = mc;
    end else begin
        bs = sc;
        be = ec;
        bm = mc;
        se = pe;
        sm = ms;
    end
    sm = ((be - se) >= 40) ? 0 : (sm >> (be - se));
    mag = (ps != sc) ? (bm - sm) : (bm + sm);
    if (mag == 0) return 32'h0;
    e = be;
    if (mag >= (64'd1 << 24)) begin
        mag = mag >> 1;
        e = e + 1;
    end
    while (mag < (64'd1 << 23)) begin
        mag = mag << 1;
        e = e - 1;
    end
    if (e < 1) return 32'h0;
    if (e >= 255) return {bs, 8'hff, 23'h0};
    return {bs, e[7:0], mag[22:0]};
endfunction

`endif

//--- dv/fp_mac_tb.sv
`default_nettype none

module fp_mac_tb import fp_mac_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    `include "fp_mac_model.svh"

    localparam int n_rand = 300;
    localparam int n_dir = 60;
    localparam int total_ops = n_rand + 4 * n_dir;
    localparam int watchdog_cycles = total_ops + 3 * n_dir + 50; // last test adds gaps

    logic        clk, rst_n, in_valid, out_valid;
    fp_word_t    a, b, acc, result, exp_word;
    logic [31:0] lfsr_state = 32'h5c5c;
    fp_word_t    expect_q[$];
    int          errors, test_errors;
    fp_word_t    x, y, z;
    logic [1:0]  strobe_hist = 2'b00; // in_valid at the last two edges
    fp_word_t    held_word = '0;

    fp_mac_top dut (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b),
                    .acc(acc), .out_valid(out_valid), .result(result));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic fp_word_t rand_word(input int e);
        logic s;
        s = 1'(take_bits(1));
        return {s, 8'(e), 23'(take_bits(23))};
    endfunction

    function automatic int clamp_exp(input int e);
        return (e < 1) ? 1 : ((e > 254) ? 254 : e);
    endfunction

    // zero, all ones, near overflow and plain random
    function automatic int pick_exp();
        case (take_bits(3))
            0: return 0;
            1: return 255;
            2, 3: return 185 + int'(take_bits(4));
            default: return int'(take_bits(8));
        endcase
    endfunction

    task automatic gen_op(input int t, output fp_word_t p, output fp_word_t q,
                          output fp_word_t r);
        int sel;
        int pe;
        sel = take_bits(2);
        p = rand_word(64 + int'(take_bits(7)));
        q = rand_word(64 + int'(take_bits(7)));
        pe = int'(p[30:23]) + int'(q[30:23]) - 127;
        r = rand_word(clamp_exp(pe + int'(take_bits(3)) - 4));
        case (t)
            1: if (sel == 0) r = rand_word(clamp_exp(pe)); // equal exponents
            2: case (sel)
                0: p = {p[31], 8'hff, p[22:0] | 23'd1};
                1: begin
                    p = {p[31], 8'hff, 23'h0};
                    q[30:23] = 8'h00;
                end
                2: begin
                    p = {p[31], 8'hff, 23'h0};
                    r = {~(p[31] ^ q[31]), 8'hff, 23'h0};
                end
                default: r = {r[31], 8'hff, r[22:0] | 23'd1};
            endcase
            3: case (sel)
                0: q = {q[31], 8'hff, 23'h0};
                1: r = {r[31], 8'hff, 23'h0};
                2: begin
                    p[30:23] = 8'(185 + take_bits(4));
                    q[30:23] = 8'(185 + take_bits(4));
                end
                default: begin
                    p[30:23] = 8'd254;
                    q[30:23] = 8'(127 + take_bits(1));
                    r = {p[31] ^ q[31], 8'd254, r[22:0]};
                end
            endcase
            4: case (sel)
                0: p[30:23] = 8'h00; // subnormal input
                1: begin
                    p[30:23] = 8'(1 + take_bits(6));
                    q[30:23] = 8'(1 + take_bits(6));
                end
                2: begin
                    q[30:23] = 8'h00;
                    r[30:23] = 8'h00;
                end
                default: begin
                    q = 32'h3f80_0000;
                    r = p ^ 32'h8000_0000;
                end
            endcase
            default: begin
                p = rand_word(pick_exp());
                q = rand_word(pick_exp());
                r = rand_word(pick_exp());
            end
        endcase
    endtask

    task automatic send(input fp_word_t p, input fp_word_t q, input fp_word_t r, input int gap);
        @(negedge clk);
        in_valid = 1'b1;
        a = p;
        b = q;
        acc = r;
        expect_q.push_back(mac_expect(p, q, r));
        repeat (gap) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic run_test(input int t, input string name, input int ops);
        for (int i = 0; i < ops; i++) begin
            gen_op(t, x, y, z);
            send(x, y, z, (t == 5) ? int'(take_bits(2)) : 0);
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (expect_q.size() > 0) @(negedge clk);
        $display("test %0d %0s: %0d ops, %0d errors", t, name, ops, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        strobe_hist <= {strobe_hist[0], in_valid};
    end

    // handshake and result checks
    always @(negedge clk) begin
        assert (out_valid === strobe_hist[1]) else begin
            $display("error at %0t: out_valid got %b expected %b", $time, out_valid,
                     strobe_hist[1]);
            test_errors++;
        end
        if (out_valid === 1'b1) begin
            assert (expect_q.size() > 0) else begin
                $display("out_valid rose at %0t with no operation pending", $time);
                test_errors++;
            end
            if (expect_q.size() > 0) begin
                exp_word = expect_q.pop_front();
                held_word = exp_word;
                assert (result == exp_word) else begin
                    $display("error at %0t: result got %h expected %h", $time, result,
                             exp_word);
                    test_errors++;
                end
            end
        end else begin
            assert (result === held_word) else begin
                $display("error at %0t: idle result got %h expected %h", $time, result,
                         held_word);
                test_errors++;
            end
        end
    end

    initial begin
        #(watchdog_cycles * 10);
        $display("watchdog expired before all operations completed");
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        acc = '0;
        errors = 0;
        test_errors = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (5) @(negedge clk); // idle cycles with no out_valid expected
        run_test(1, "finite", n_rand);
        run_test(2, "nan", n_dir);
        run_test(3, "infinity", n_dir);
        run_test(4, "zero", n_dir);
        run_test(5, "spacing", n_dir);
        $display("5 tests, %0d operations, %0d errors", total_ops, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/fp_add.sv
`default_nettype none

module fp_add import fp_mac_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     prod_valid,
    input  logic     prod_sign,
    input  logic     prod_zero,
    input  logic     prod_inf,
    input  logic     special_hit,
    input  fp_wexp_t prod_exp,
    input  fp_sig_t  prod_sig,
    input  fp_word_t acc_q,
    input  fp_word_t special_word,
    output logic     out_valid,
    output fp_word_t result
);

    fp_exp_t     acc_exp;
    logic        acc_zero;
    fp_wexp_t    acc_exp_w;
    fp_sig_t     acc_sig;

    logic        prod_big;
    logic        big_sign;
    fp_wexp_t    big_exp;
    fp_wexp_t    small_exp;
    fp_sig_t     big_sig;
    fp_sig_t     small_sig;
    fp_wexp_t    exp_diff;
    logic [9:0]  shift_amt;
    fp_sig_t     aligned_sig;

    logic        eff_sub;
    logic [24:0] mag;
    logic [4:0]  lead;
    logic [24:0] norm_mag;
    fp_sig_t     norm_sig;
    fp_wexp_t    norm_exp;

    fp_word_t    word_d;

    assign acc_exp = acc_q[30:23];
    assign acc_zero = (acc_exp == '0);
    assign acc_exp_w = fp_wexp_t'({2'b00, acc_exp});
    assign acc_sig = acc_zero ? '0 : {1'b1, acc_q[frac_w-1:0]};

    // order by exponent, then by significand
    assign prod_big = (prod_exp > acc_exp_w)
                   || ((prod_exp == acc_exp_w) && (prod_sig >= acc_sig));

    always_comb begin
        if (prod_big) begin
            big_sign  = prod_sign;
            big_exp   = prod_exp;
            big_sig   = prod_sig;
            small_exp = acc_exp_w;
            small_sig = acc_sig;
        end else begin
            big_sign  = acc_q[31];
            big_exp   = acc_exp_w;
            big_sig   = acc_sig;
            small_exp = prod_exp;
            small_sig = prod_sig;
        end
    end

    assign exp_diff = big_exp - small_exp; // never negative after ordering
    assign shift_amt = exp_diff;
    assign aligned_sig = small_sig >> shift_amt; // shifted-out bits dropped

    // big >= aligned, so the difference cannot wrap
    assign eff_sub = prod_sign ^ acc_q[31];
    assign mag = eff_sub ? ({1'b0, big_sig} - {1'b0, aligned_sig})
                         : ({1'b0, big_sig} + {1'b0, aligned_sig});

    assign lead = lead_one_pos(mag);

    always_comb begin
        if (lead == 5'd24) begin
            norm_mag = mag >> 1; // carry out of the add
        end else begin
            norm_mag = mag << (5'd23 - lead); // cancellation
        end
    end

    assign norm_sig = norm_mag[23:0];
    assign norm_exp = big_exp + fp_wexp_t'({5'b00000, lead}) - fp_wexp_t'(frac_w);

    always_comb begin
        if (special_hit) begin
            word_d = special_word;
        end else if (prod_inf) begin
            word_d = {prod_sign, fp_exp_t'(exp_all_ones), fp_frac_t'(0)};
        end else if (prod_zero) begin
            word_d = acc_zero ? '0 : acc_q; // flush a subnormal acc
        end else if ((mag == '0) || (norm_exp < fp_wexp_t'(1))) begin
            word_d = '0; // exact zero and underflow give +0
        end else if (norm_exp >= fp_wexp_t'(exp_all_ones)) begin
            word_d = {big_sign, fp_exp_t'(exp_all_ones), fp_frac_t'(0)};
        end else begin
            word_d = {big_sign, norm_exp[7:0], norm_sig[frac_w-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= prod_valid;
            if (prod_valid) begin
                result <= word_d; // held between operations
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/fp_mac_pkg.sv
`default_nettype none

package fp_mac_pkg;

    // single-precision field types
    typedef logic [31:0] fp_word_t;
    typedef logic [7:0] fp_exp_t;
    typedef logic [22:0] fp_frac_t;
    typedef logic [23:0] fp_sig_t;

    // signed and two bits wider, so under- and overflow stay visible
    typedef logic signed [9:0] fp_wexp_t;

    localparam int exp_bias = 127;
    localparam int exp_all_ones = 255;
    localparam int frac_w = 23;

    localparam fp_word_t qnan_word = 32'h7fff_ffff;

    // index of the highest set bit or 0 for an all-zero vector
    function automatic logic [4:0] lead_one_pos(input logic [24:0] v);
        logic [4:0] pos;
        pos = '0;
        for (int i = 0; i < 25; i++) begin
            if (v[i]) begin
                pos = 5'(i); // later hits win
            end
        end
        return pos;
    endfunction

endpackage

`default_nettype wire

//--- logic/fp_mac_top.sv
`default_nettype none

module fp_mac_top import fp_mac_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  fp_word_t a,
    input  fp_word_t b,
    input  fp_word_t acc,
    output logic     out_valid,
    output fp_word_t result
);

    // stage one to stage two
    logic     special_hit;
    fp_word_t special_word;
    logic     prod_valid;
    logic     prod_sign;
    logic     prod_zero;
    logic     prod_inf;
    fp_wexp_t prod_exp;
    fp_sig_t  prod_sig;
    fp_word_t acc_q;

    fp_special u_special (
        .clk          (clk),
        .rst_n        (rst_n),
        .a            (a),
        .b            (b),
        .acc          (acc),
        .special_hit  (special_hit),
        .special_word (special_word)
    );

    fp_mul u_mul (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .a          (a),
        .b          (b),
        .acc        (acc),
        .prod_valid (prod_valid),
        .prod_sign  (prod_sign),
        .prod_zero  (prod_zero),
        .prod_inf   (prod_inf),
        .prod_exp   (prod_exp),
        .prod_sig   (prod_sig),
        .acc_q      (acc_q)
    );

    fp_add u_add (
        .clk          (clk),
        .rst_n        (rst_n),
        .prod_valid   (prod_valid),
        .prod_sign    (prod_sign),
        .prod_zero    (prod_zero),
        .prod_inf     (prod_inf),
        .special_hit  (special_hit),
        .prod_exp     (prod_exp),
        .prod_sig     (prod_sig),
        .acc_q        (acc_q),
        .special_word (special_word),
        .out_valid    (out_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- logic/fp_mul.sv
`default_nettype none

module fp_mul import fp_mac_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  fp_word_t a,
    input  fp_word_t b,
    input  fp_word_t acc,
    output logic     prod_valid,
    output logic     prod_sign,
    output logic     prod_zero,
    output logic     prod_inf,
    output fp_wexp_t prod_exp,
    output fp_sig_t  prod_sig,
    output fp_word_t acc_q
);

    fp_exp_t     a_exp, b_exp;
    fp_frac_t    a_frac, b_frac;
    logic        a_zero, b_zero;
    fp_sig_t     a_sig, b_sig;
    logic [47:0] full_prod;
    fp_wexp_t    exp_sum;
    fp_wexp_t    exp_norm;
    fp_sig_t     sig_norm;
    logic        zero_d;
    logic        inf_d;

    // field unpack
    assign a_exp = a[30:23];
    assign b_exp = b[30:23];
    assign a_frac = a[frac_w-1:0];
    assign b_frac = b[frac_w-1:0];

    assign a_zero = (a_exp == '0);
    assign b_zero = (b_exp == '0);

    // hidden one always set as zero inputs are caught by the flags
    assign a_sig = {1'b1, a_frac};
    assign b_sig = {1'b1, b_frac};

    assign full_prod = a_sig * b_sig; // 1.x * 1.x lands in [1, 4)

    assign exp_sum = fp_wexp_t'({2'b00, a_exp})
                   + fp_wexp_t'({2'b00, b_exp})
                   - fp_wexp_t'(exp_bias);

    always_comb begin
        if (full_prod[47]) begin
            sig_norm = full_prod[47:24]; // product >= 2 needs a one-place shift
            exp_norm = exp_sum + fp_wexp_t'(1);
        end else begin
            sig_norm = full_prod[46:23];
            exp_norm = exp_sum;
        end
    end

    assign zero_d = a_zero | b_zero | (exp_norm < fp_wexp_t'(1));
    assign inf_d = (exp_norm >= fp_wexp_t'(exp_all_ones));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

    // payload follows the inputs every cycle and is qualified by prod_valid
    always_ff @(posedge clk) begin
        prod_sign <= a[31] ^ b[31];
        prod_zero <= zero_d;
        prod_inf  <= inf_d;
        prod_exp  <= exp_norm;
        prod_sig  <= sig_norm;
        acc_q     <= acc;
    end

endmodule

`default_nettype wire

//--- logic/fp_special.sv
`default_nettype none

module fp_special import fp_mac_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  fp_word_t a,
    input  fp_word_t b,
    input  fp_word_t acc,
    output logic     special_hit,
    output fp_word_t special_word
);

    function automatic logic is_nan(input fp_word_t w);
        return (w[30:23] == fp_exp_t'(exp_all_ones)) && (w[frac_w-1:0] != '0);
    endfunction

    function automatic logic is_inf(input fp_word_t w);
        return (w[30:23] == fp_exp_t'(exp_all_ones)) && (w[frac_w-1:0] == '0);
    endfunction

    function automatic logic is_zero(input fp_word_t w);
        return w[30:23] == '0; // subnormals count as zero
    endfunction

    logic     any_nan;
    logic     a_inf, b_inf, acc_inf;
    logic     a_zero, b_zero;
    logic     mul_sign;
    logic     mul_inf;
    logic     inf_times_zero;
    logic     inf_clash;
    logic     hit_d;
    fp_word_t word_d;

    assign any_nan = is_nan(a) | is_nan(b) | is_nan(acc);
    assign a_inf = is_inf(a);
    assign b_inf = is_inf(b);
    assign acc_inf = is_inf(acc);
    assign a_zero = is_zero(a);
    assign b_zero = is_zero(b);

    assign mul_sign = a[31] ^ b[31];
    assign mul_inf = (a_inf | b_inf) & ~a_zero & ~b_zero;
    assign inf_times_zero = (a_inf & b_zero) | (b_inf & a_zero);
    assign inf_clash = mul_inf & acc_inf & (mul_sign != acc[31]); // inf - inf

    always_comb begin
        hit_d = any_nan | a_inf | b_inf | acc_inf;
        if (any_nan | inf_times_zero | inf_clash) begin
            word_d = qnan_word;
        end else if (mul_inf) begin
            word_d = {mul_sign, fp_exp_t'(exp_all_ones), fp_frac_t'(0)};
        end else begin
            word_d = acc; // only an infinite acc is left
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            special_hit <= 1'b0;
        end else begin
            special_hit <= hit_d;
        end
    end

    always_ff @(posedge clk) begin
        special_word <= word_d;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+dv
logic/fp_mac_pkg.sv
logic/fp_special.sv
logic/fp_mul.sv
logic/fp_add.sv
logic/fp_mac_top.sv
dv/fp_mac_chk.sv
dv/fp_mac_tb.sv
